//--- list.f
verilog/axil_pkg.sv
verilog/pr_pkg.sv
verilog/axil_decoupler.sv
verilog/axil_txn_tracker.sv
verilog/pr_ctrl.sv
verilog/region_regs.sv
verilog/pr_shell_top.sv
sim/tb_pr_shell.sv

//--- sim/tb_pr_shell.sv
// -------------------------------------------------------------------
// testbench for the PR shell, two regions, RST_CYCLES 8
// steps come from a table built at run time, data from a seeded rng
// outputs sampled 1 ns after a falling edge, inputs driven on it
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_pr_shell;

	localparam int CLK_PERIOD = 40;
	localparam int NR         = 2;
	localparam int AB         = 12;
	localparam int DB         = 32;

	typedef enum {K_WRITE, K_READ, K_CMD, K_RD_DEC, K_WR_HOLD} step_kind_e;

	typedef struct {
		step_kind_e      kind;
		int              region;
		logic [AB-1:0]   addr;
		logic [DB-1:0]   data;
		logic [DB/8-1:0] strb;
		pr_pkg::pr_cmd_e op;
	} step_t;

	logic aclk;
	logic arst_n;
	logic cmd_valid;
	pr_pkg::pr_cmd_e cmd_op;
	logic [0:0] cmd_region;
	logic cmd_ready;
	logic cmd_done;
	logic [NR-1:0] decoupled;
	logic [NR-1:0][AB-1:0] s_axil_awaddr;
	logic [NR-1:0][2:0] s_axil_awprot;
	logic [NR-1:0] s_axil_awvalid;
	logic [NR-1:0] s_axil_awready;
	logic [NR-1:0][DB-1:0] s_axil_wdata;
	logic [NR-1:0][DB/8-1:0] s_axil_wstrb;
	logic [NR-1:0] s_axil_wvalid;
	logic [NR-1:0] s_axil_wready;
	logic [NR-1:0][1:0] s_axil_bresp;
	logic [NR-1:0] s_axil_bvalid;
	logic [NR-1:0] s_axil_bready;
	logic [NR-1:0][AB-1:0] s_axil_araddr;
	logic [NR-1:0][2:0] s_axil_arprot;
	logic [NR-1:0] s_axil_arvalid;
	logic [NR-1:0] s_axil_arready;
	logic [NR-1:0][DB-1:0] s_axil_rdata;
	logic [NR-1:0][1:0] s_axil_rresp;
	logic [NR-1:0] s_axil_rvalid;
	logic [NR-1:0] s_axil_rready;

	// reference model of every region's register file
	logic [DB-1:0] model_regs [NR][axil_pkg::REG_WORDS];
	logic [NR-1:0] exp_decoupled;
	step_t         steps [$];
	int            n_steps;

	pr_shell_top #(.N_REGIONS(NR), .ADDR_BITS(AB), .DATA_BITS(DB), .RST_CYCLES(8))
	pr_shell_top_inst (
		.aclk(aclk), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_region(cmd_region),
		.cmd_ready(cmd_ready), .cmd_done(cmd_done), .decoupled(decoupled),
		.s_axil_awaddr(s_axil_awaddr), .s_axil_awprot(s_axil_awprot),
		.s_axil_awvalid(s_axil_awvalid), .s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata), .s_axil_wstrb(s_axil_wstrb),
		.s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr), .s_axil_arprot(s_axil_arprot),
		.s_axil_arvalid(s_axil_arvalid), .s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready)
	);

	always #(CLK_PERIOD / 2) aclk = ~aclk;

	// -------------------------------------------------------------------
	// checking and reference model
	// -------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// word index from the byte address, 4 bytes per word
	function automatic logic [31:0] expected_resp(input logic [AB-1:0] addr);
		return (addr[AB-1:2] < axil_pkg::REG_WORDS) ? axil_pkg::OKAY : axil_pkg::SLVERR;
	endfunction

	function automatic logic [DB-1:0] expected_data(input int r, input logic [AB-1:0] addr);
		return (addr[AB-1:2] < axil_pkg::REG_WORDS) ? model_regs[r][addr[3:2]] : '0;
	endfunction

	// byte lanes under strobe take the new data
	task automatic update_model(input int r, input logic [AB-1:0] addr,
			input logic [DB-1:0] data, input logic [DB/8-1:0] strb);
		if (addr[AB-1:2] < axil_pkg::REG_WORDS) begin
			for (int b = 0; b < DB / 8; b++) begin
				if (strb[b]) model_regs[r][addr[3:2]][b*8 +: 8] = data[b*8 +: 8];
			end
		end
	endtask

	task automatic add_step(input step_kind_e kind, input int r, input logic [AB-1:0] addr,
			input pr_pkg::pr_cmd_e op);
		step_t st;
		st.kind   = kind;
		st.region = r;
		st.addr   = addr;
		st.data   = $urandom;
		st.strb   = 4'($urandom);
		st.op     = op;
		steps.push_back(st);
	endtask

	// -------------------------------------------------------------------
	// host side AXI4-Lite and command tasks
	// -------------------------------------------------------------------
	// valids held until awready, bready set once they drop
	task automatic do_write(input int r, input logic [AB-1:0] addr, input logic [DB-1:0] data,
			input logic [DB/8-1:0] strb, input bit release_b, output logic [1:0] resp);
		@(negedge aclk);
		s_axil_awaddr[r]  = addr;
		s_axil_wdata[r]   = data;
		s_axil_wstrb[r]   = strb;
		s_axil_awvalid[r] = 1'b1;
		s_axil_wvalid[r]  = 1'b1;
		#1;
		while (!s_axil_awready[r]) begin
			@(negedge aclk);
			#1;
		end
		// aw and w are taken together
		check_value($sformatf("s_axil_wready[%0d]", r), s_axil_wready[r], 1'b1);
		@(negedge aclk);
		s_axil_awvalid[r] = 1'b0;
		s_axil_wvalid[r]  = 1'b0;
		s_axil_bready[r]  = release_b;
		#1;
		// response one cycle after the handshake
		check_value($sformatf("s_axil_bvalid[%0d]", r), s_axil_bvalid[r], 1'b1);
		resp = s_axil_bresp[r];
		if (release_b) begin
			@(negedge aclk);
			s_axil_bready[r] = 1'b0;
		end
	endtask

	// rvalid only rises after the ar handshake, held while rready is low
	task automatic read_and_compare(input int r, input logic [AB-1:0] addr);
		@(negedge aclk);
		s_axil_araddr[r]  = addr;
		s_axil_arvalid[r] = 1'b1;
		#1;
		while (!s_axil_rvalid[r]) begin
			@(negedge aclk);
			#1;
		end
		check_value($sformatf("s_axil_rdata[%0d]", r), s_axil_rdata[r], expected_data(r, addr));
		check_value($sformatf("s_axil_rresp[%0d]", r), s_axil_rresp[r], expected_resp(addr));
		@(negedge aclk);
		s_axil_arvalid[r] = 1'b0;
		s_axil_rready[r]  = 1'b1;
		@(negedge aclk);
		s_axil_rready[r] = 1'b0;
	endtask

	// one-cycle strobe, cmd_ready is high between commands
	task automatic issue_command(input pr_pkg::pr_cmd_e op, input int r);
		@(negedge aclk);
		cmd_valid  = 1'b1;
		cmd_op     = op;
		cmd_region = 1'(r);
		@(negedge aclk);
		cmd_valid = 1'b0;
		cmd_op    = pr_pkg::CMD_NOP;
	endtask

	task automatic finish_command(input pr_pkg::pr_cmd_e op, input int r);
		#1;
		while (!cmd_done) begin
			@(negedge aclk);
			#1;
		end
		// decouple also reset the region, so the model is cleared
		if (op == pr_pkg::CMD_DECOUPLE) begin
			exp_decoupled[r] = 1'b1;
			for (int w = 0; w < axil_pkg::REG_WORDS; w++) model_regs[r][w] = '0;
		end else if (op == pr_pkg::CMD_COUPLE) begin
			exp_decoupled[r] = 1'b0;
		end
		check_value("decoupled", decoupled, exp_decoupled);
		@(negedge aclk);
		#1;
		check_value("cmd_ready", cmd_ready, 1'b1);
		check_value("cmd_done", cmd_done, 1'b0);
	endtask

	// read into a decoupled region, freed later by a couple command
	task automatic stalled_read(input int r, input logic [AB-1:0] addr);
		@(negedge aclk);
		s_axil_araddr[r]  = addr;
		s_axil_arvalid[r] = 1'b1;
		repeat (20) begin
			#1;
			check_value($sformatf("s_axil_arready[%0d]", r), s_axil_arready[r], 1'b0);
			@(negedge aclk);
		end
		// the other region keeps serving meanwhile
		read_and_compare(1 - r, addr);
		issue_command(pr_pkg::CMD_COUPLE, r);
		finish_command(pr_pkg::CMD_COUPLE, r);
		while (!s_axil_rvalid[r]) begin
			@(negedge aclk);
			#1;
		end
		check_value($sformatf("s_axil_rdata[%0d]", r), s_axil_rdata[r], expected_data(r, addr));
		check_value($sformatf("s_axil_rresp[%0d]", r), s_axil_rresp[r], expected_resp(addr));
		@(negedge aclk);
		s_axil_arvalid[r] = 1'b0;
		s_axil_rready[r]  = 1'b1;
		@(negedge aclk);
		s_axil_rready[r] = 1'b0;
	endtask

	// pending b response must hold the drain
	task automatic held_write_decouple(input step_t st);
		logic [1:0] resp;
		do_write(st.region, st.addr, st.data, st.strb, 1'b0, resp);
		check_value("s_axil_bresp", resp, expected_resp(st.addr));
		update_model(st.region, st.addr, st.data, st.strb);
		issue_command(pr_pkg::CMD_DECOUPLE, st.region);
		repeat (20) begin
			#1;
			check_value("cmd_done", cmd_done, 1'b0);
			@(negedge aclk);
		end
		s_axil_bready[st.region] = 1'b1;
		@(negedge aclk);
		s_axil_bready[st.region] = 1'b0;
		finish_command(pr_pkg::CMD_DECOUPLE, st.region);
	endtask

	// -------------------------------------------------------------------
	// stimulus table and main sequence
	// -------------------------------------------------------------------
	task automatic build_table();
		for (int r = 0; r < NR; r++)
			for (int w = 0; w < axil_pkg::REG_WORDS; w++)
				add_step(K_WRITE, r, AB'(w * 4), pr_pkg::CMD_NOP);
		for (int r = 0; r < NR; r++)
			for (int w = 0; w < axil_pkg::REG_WORDS; w++)
				add_step(K_READ, r, AB'(w * 4), pr_pkg::CMD_NOP);
		// out of range, word 4 would alias word 0 if truncated
		add_step(K_WRITE, 0, 12'h010, pr_pkg::CMD_NOP);
		add_step(K_READ, 0, 12'h010, pr_pkg::CMD_NOP);
		add_step(K_READ, 0, 12'h7fc, pr_pkg::CMD_NOP);
		add_step(K_READ, 0, 12'h000, pr_pkg::CMD_NOP);
		add_step(K_CMD, 0, 12'h000, pr_pkg::CMD_NOP);
		add_step(K_CMD, 0, 12'h000, pr_pkg::CMD_DECOUPLE);
		add_step(K_RD_DEC, 0, 12'h004, pr_pkg::CMD_NOP);
		add_step(K_READ, 1, 12'h008, pr_pkg::CMD_NOP);
		add_step(K_READ, 0, 12'h00c, pr_pkg::CMD_NOP);
		add_step(K_WR_HOLD, 1, 12'h004, pr_pkg::CMD_NOP);
		add_step(K_CMD, 1, 12'h000, pr_pkg::CMD_COUPLE);
		add_step(K_READ, 1, 12'h004, pr_pkg::CMD_NOP);
		add_step(K_READ, 0, 12'h004, pr_pkg::CMD_NOP);
	endtask

	initial begin
		int         seed_val;
		logic [1:0] resp;
		seed_val = $urandom(32'hb30c);
		aclk = 1'b0;
		arst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = pr_pkg::CMD_NOP;
		cmd_region = '0;
		s_axil_awaddr = '0;
		s_axil_awprot = '0;
		s_axil_awvalid = '0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_wvalid = '0;
		s_axil_bready = '0;
		s_axil_araddr = '0;
		s_axil_arprot = '0;
		s_axil_arvalid = '0;
		s_axil_rready = '0;
		exp_decoupled = '0;
		for (int r = 0; r < NR; r++)
			for (int w = 0; w < axil_pkg::REG_WORDS; w++) model_regs[r][w] = '0;
		build_table();
		n_steps = steps.size();
		repeat (3) @(posedge aclk);
		@(negedge aclk);
		arst_n = 1'b1;
		#1;
		// state straight out of reset
		check_value("cmd_ready", cmd_ready, 1'b1);
		check_value("cmd_done", cmd_done, 1'b0);
		check_value("decoupled", decoupled, '0);
		check_value("s_axil_bvalid", s_axil_bvalid, '0);
		check_value("s_axil_rvalid", s_axil_rvalid, '0);
		foreach (steps[i]) begin
			case (steps[i].kind)
				K_WRITE: begin
					do_write(steps[i].region, steps[i].addr, steps[i].data, steps[i].strb,
						1'b1, resp);
					check_value("s_axil_bresp", resp, expected_resp(steps[i].addr));
					update_model(steps[i].region, steps[i].addr, steps[i].data, steps[i].strb);
				end
				K_READ: read_and_compare(steps[i].region, steps[i].addr);
				K_CMD: begin
					issue_command(steps[i].op, steps[i].region);
					finish_command(steps[i].op, steps[i].region);
				end
				K_RD_DEC: stalled_read(steps[i].region, steps[i].addr);
				default: held_write_decouple(steps[i]);
			endcase
		end
		$display("TEST PASS");
		$finish;
	end

	// watchdog, 200 cycles per step plus reset margin
	initial begin
		wait (n_steps > 0);
		#((n_steps * 200 + 10) * CLK_PERIOD);
		$display("watchdog expired, the run hung with the controller in %s",
			pr_shell_top_inst.pr_ctrl_inst.state.name());
		$display("TEST FAIL");
		$fatal(1, "simulation timed out");
	end

endmodule

`default_nettype wire

//--- verilog/pr_shell_top.sv
// -------------------------------------------------------------------
// partial-reconfiguration shell, one AXI4-Lite port per region
// decoupler adds no latency, prot is carried but not used
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pr_shell_top #(
	parameter int N_REGIONS  = 2,
	parameter int ADDR_BITS  = 12,
	parameter int DATA_BITS  = 32,
	parameter int RST_CYCLES = 8,
	parameter int CNT_BITS   = 4,
	localparam int IDX_BITS  = (N_REGIONS > 1) ? $clog2(N_REGIONS) : 1,
	localparam int RB        = axil_pkg::AXIL_RESP_BITS
) (
	input  wire                  aclk,
	input  wire                  arst_n,
	// reconfiguration commands
	input  wire                  cmd_valid,
	input  wire pr_pkg::pr_cmd_e cmd_op,
	input  wire [IDX_BITS-1:0]   cmd_region,
	output logic                 cmd_ready,
	output logic                 cmd_done,
	output logic [N_REGIONS-1:0] decoupled,
	// host AXI4-Lite, one port per region
	input  wire [N_REGIONS-1:0][ADDR_BITS-1:0]                s_axil_awaddr,
	input  wire [N_REGIONS-1:0][axil_pkg::AXIL_PROT_BITS-1:0] s_axil_awprot,
	input  wire [N_REGIONS-1:0]                               s_axil_awvalid,
	output logic [N_REGIONS-1:0]                              s_axil_awready,
	input  wire [N_REGIONS-1:0][DATA_BITS-1:0]                s_axil_wdata,
	input  wire [N_REGIONS-1:0][DATA_BITS/8-1:0]              s_axil_wstrb,
	input  wire [N_REGIONS-1:0]                               s_axil_wvalid,
	output logic [N_REGIONS-1:0]                              s_axil_wready,
	output logic [N_REGIONS-1:0][RB-1:0]                      s_axil_bresp,
	output logic [N_REGIONS-1:0]                              s_axil_bvalid,
	input  wire [N_REGIONS-1:0]                               s_axil_bready,
	input  wire [N_REGIONS-1:0][ADDR_BITS-1:0]                s_axil_araddr,
	input  wire [N_REGIONS-1:0][axil_pkg::AXIL_PROT_BITS-1:0] s_axil_arprot,
	input  wire [N_REGIONS-1:0]                               s_axil_arvalid,
	output logic [N_REGIONS-1:0]                              s_axil_arready,
	output logic [N_REGIONS-1:0][DATA_BITS-1:0]               s_axil_rdata,
	output logic [N_REGIONS-1:0][RB-1:0]                      s_axil_rresp,
	output logic [N_REGIONS-1:0]                              s_axil_rvalid,
	input  wire [N_REGIONS-1:0]                               s_axil_rready
);

	// region side of the decoupler
	logic [N_REGIONS-1:0][ADDR_BITS-1:0]   m_axil_awaddr;
	logic [N_REGIONS-1:0]                  m_axil_awvalid;
	logic [N_REGIONS-1:0]                  m_axil_awready;
	logic [N_REGIONS-1:0][DATA_BITS-1:0]   m_axil_wdata;
	logic [N_REGIONS-1:0][DATA_BITS/8-1:0] m_axil_wstrb;
	logic [N_REGIONS-1:0]                  m_axil_wvalid;
	logic [N_REGIONS-1:0]                  m_axil_wready;
	logic [N_REGIONS-1:0][RB-1:0]          m_axil_bresp;
	logic [N_REGIONS-1:0]                  m_axil_bvalid;
	logic [N_REGIONS-1:0]                  m_axil_bready;
	logic [N_REGIONS-1:0][ADDR_BITS-1:0]   m_axil_araddr;
	logic [N_REGIONS-1:0]                  m_axil_arvalid;
	logic [N_REGIONS-1:0]                  m_axil_arready;
	logic [N_REGIONS-1:0][DATA_BITS-1:0]   m_axil_rdata;
	logic [N_REGIONS-1:0][RB-1:0]          m_axil_rresp;
	logic [N_REGIONS-1:0]                  m_axil_rvalid;
	logic [N_REGIONS-1:0]                  m_axil_rready;
	// control
	logic [N_REGIONS-1:0]                  region_idle;
	logic [N_REGIONS-1:0]                  region_rst;

	// -------------------------------------------------------------------
	// control path
	// -------------------------------------------------------------------
	pr_ctrl #(.N_REGIONS(N_REGIONS), .RST_CYCLES(RST_CYCLES)) pr_ctrl_inst (
		.aclk(aclk), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_region(cmd_region),
		.region_idle(region_idle), .cmd_ready(cmd_ready), .cmd_done(cmd_done),
		.decouple(decoupled), .region_rst(region_rst)
	);

	// watches the host side, so decoupled traffic is never counted
	axil_txn_tracker #(.N_REGIONS(N_REGIONS), .CNT_BITS(CNT_BITS)) axil_txn_tracker_inst (
		.aclk(aclk), .arst_n(arst_n),
		.awvalid(s_axil_awvalid), .awready(s_axil_awready), .wvalid(s_axil_wvalid),
		.bvalid(s_axil_bvalid), .bready(s_axil_bready),
		.arvalid(s_axil_arvalid), .arready(s_axil_arready),
		.rvalid(s_axil_rvalid), .rready(s_axil_rready), .region_idle(region_idle)
	);

	// -------------------------------------------------------------------
	// datapath
	// -------------------------------------------------------------------
	axil_decoupler #(
		.N_REGIONS(N_REGIONS), .ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)
	) axil_decoupler_inst (
		.decouple(decoupled),
		.s_axil_awaddr(s_axil_awaddr), .s_axil_awprot(s_axil_awprot),
		.s_axil_awvalid(s_axil_awvalid), .s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata), .s_axil_wstrb(s_axil_wstrb),
		.s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr), .s_axil_arprot(s_axil_arprot),
		.s_axil_arvalid(s_axil_arvalid), .s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
		.m_axil_awaddr(m_axil_awaddr), .m_axil_awprot(),
		.m_axil_awvalid(m_axil_awvalid), .m_axil_awready(m_axil_awready),
		.m_axil_wdata(m_axil_wdata), .m_axil_wstrb(m_axil_wstrb),
		.m_axil_wvalid(m_axil_wvalid), .m_axil_wready(m_axil_wready),
		.m_axil_bresp(m_axil_bresp), .m_axil_bvalid(m_axil_bvalid),
		.m_axil_bready(m_axil_bready),
		.m_axil_araddr(m_axil_araddr), .m_axil_arprot(),
		.m_axil_arvalid(m_axil_arvalid), .m_axil_arready(m_axil_arready),
		.m_axil_rdata(m_axil_rdata), .m_axil_rresp(m_axil_rresp),
		.m_axil_rvalid(m_axil_rvalid), .m_axil_rready(m_axil_rready)
	);

	// one user core per region
	for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
		region_regs #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) region_regs_inst (
			.aclk(aclk), .arst_n(arst_n), .region_rst(region_rst[i]),
			.awaddr(m_axil_awaddr[i]), .awvalid(m_axil_awvalid[i]),
			.awready(m_axil_awready[i]),
			.wdata(m_axil_wdata[i]), .wstrb(m_axil_wstrb[i]),
			.wvalid(m_axil_wvalid[i]), .wready(m_axil_wready[i]),
			.bresp(m_axil_bresp[i]), .bvalid(m_axil_bvalid[i]), .bready(m_axil_bready[i]),
			.araddr(m_axil_araddr[i]), .arvalid(m_axil_arvalid[i]),
			.arready(m_axil_arready[i]),
			.rdata(m_axil_rdata[i]), .rresp(m_axil_rresp[i]),
			.rvalid(m_axil_rvalid[i]), .rready(m_axil_rready[i])
		);
	end

endmodule

`default_nettype wire

//--- verilog/region_regs.sv
// -------------------------------------------------------------------
// stand-in user core, REG_WORDS registers behind an AXI4-Lite slave
// aw and w must arrive together, one response outstanding per kind
// word index at or above REG_WORDS gives SLVERR and reads zero
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module region_regs #(
	parameter int ADDR_BITS = 12,
	parameter int DATA_BITS = 32
) (
	input  wire                    aclk,
	input  wire                    arst_n,
	input  wire                    region_rst,
	input  wire [ADDR_BITS-1:0]    awaddr,
	input  wire                    awvalid,
	output logic                   awready,
	input  wire [DATA_BITS-1:0]    wdata,
	input  wire [DATA_BITS/8-1:0]  wstrb,
	input  wire                    wvalid,
	output logic                   wready,
	output axil_pkg::axil_resp_e   bresp,
	output logic                   bvalid,
	input  wire                    bready,
	input  wire [ADDR_BITS-1:0]    araddr,
	input  wire                    arvalid,
	output logic                   arready,
	output logic [DATA_BITS-1:0]   rdata,
	output axil_pkg::axil_resp_e   rresp,
	output logic                   rvalid,
	input  wire                    rready
);

	localparam int OFFS      = $clog2(DATA_BITS / 8);
	localparam int WORD_BITS = ADDR_BITS - OFFS;
	localparam int IDX_BITS  = $clog2(axil_pkg::REG_WORDS);

	logic [DATA_BITS-1:0] regs [axil_pkg::REG_WORDS];
	logic [WORD_BITS-1:0] aw_word;
	logic [WORD_BITS-1:0] ar_word;
	logic                 aw_ok;
	logic                 ar_ok;
	logic                 wr_hs;
	logic                 rd_hs;

	// byte address to word index
	assign aw_word = awaddr[ADDR_BITS-1:OFFS];
	assign ar_word = araddr[ADDR_BITS-1:OFFS];
	assign aw_ok   = aw_word < axil_pkg::REG_WORDS;
	assign ar_ok   = ar_word < axil_pkg::REG_WORDS;

	// held response blocks the next request of its kind
	assign wr_hs   = awvalid && wvalid && !bvalid;
	assign awready = wr_hs;
	assign wready  = wr_hs;
	assign rd_hs   = arvalid && !rvalid;
	assign arready = !rvalid;

	// -------------------------------------------------------------------
	// registers and response flags
	// -------------------------------------------------------------------
	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			for (int w = 0; w < axil_pkg::REG_WORDS; w++) regs[w] <= '0;
		end else if (region_rst) begin
			// reconfiguration wipes contents and pending responses
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			for (int w = 0; w < axil_pkg::REG_WORDS; w++) regs[w] <= '0;
		end else begin
			if (wr_hs) bvalid <= 1'b1;
			else if (bready) bvalid <= 1'b0;
			if (rd_hs) rvalid <= 1'b1;
			else if (rready) rvalid <= 1'b0;
			// byte strobes
			if (wr_hs && aw_ok) begin
				for (int b = 0; b < DATA_BITS / 8; b++) begin
					if (wstrb[b]) regs[aw_word[IDX_BITS-1:0]][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// response payloads, only valid alongside their flags
	always_ff @(posedge aclk) begin
		if (wr_hs) bresp <= aw_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
		if (rd_hs) begin
			rdata <= ar_ok ? regs[ar_word[IDX_BITS-1:0]] : '0;
			rresp <= ar_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pr_ctrl.sv
// -------------------------------------------------------------------
// reconfiguration command FSM, one region at a time
// commands while cmd_ready is low are dropped, not queued
// decouple of an already decoupled region with a stalled host
// request never drains
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pr_ctrl #(
	parameter int N_REGIONS  = 2,
	parameter int RST_CYCLES = 8,
	localparam int IDX_BITS  = (N_REGIONS > 1) ? $clog2(N_REGIONS) : 1
) (
	input  wire                  aclk,
	input  wire                  arst_n,
	input  wire                  cmd_valid,
	input  wire pr_pkg::pr_cmd_e cmd_op,
	input  wire [IDX_BITS-1:0]   cmd_region,
	input  wire [N_REGIONS-1:0]  region_idle,
	output logic                 cmd_ready,
	output logic                 cmd_done,
	output logic [N_REGIONS-1:0] decouple,
	output logic [N_REGIONS-1:0] region_rst
);

	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	pr_pkg::pr_state_e   state;
	logic [IDX_BITS-1:0] target;
	logic [CNT_W-1:0]    rst_cnt;

	// status straight from the state
	assign cmd_ready = (state == pr_pkg::ST_IDLE);
	assign cmd_done  = (state == pr_pkg::ST_DONE);

	// -------------------------------------------------------------------
	// state machine
	// -------------------------------------------------------------------
	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= pr_pkg::ST_IDLE;
			target     <= '0;
			rst_cnt    <= '0;
			decouple   <= '0;
			region_rst <= '0;
		end else begin
			case (state)
				pr_pkg::ST_IDLE: begin
					// cmd_ready is high here, so valid alone accepts
					if (cmd_valid) begin
						target <= cmd_region;
						case (cmd_op)
							pr_pkg::CMD_DECOUPLE: begin
								state <= pr_pkg::ST_DRAIN;
							end
							pr_pkg::CMD_COUPLE: begin
								// no drain, region just opens up again
								decouple[cmd_region] <= 1'b0;
								state                <= pr_pkg::ST_DONE;
							end
							default: begin
								state <= pr_pkg::ST_DONE;
							end
						endcase
					end
				end

				pr_pkg::ST_DRAIN: begin
					// idle implies no valid this cycle, so nothing is
					// accepted on the edge where decouple turns on
					if (region_idle[target]) begin
						decouple[target]   <= 1'b1;
						region_rst[target] <= 1'b1;
						rst_cnt            <= '0;
						state              <= pr_pkg::ST_RESET;
					end
				end

				pr_pkg::ST_RESET: begin
					// stand-in for the bitstream load
					if (rst_cnt == CNT_W'(RST_CYCLES - 1)) begin
						region_rst[target] <= 1'b0;
						state              <= pr_pkg::ST_DONE;
					end else begin
						rst_cnt <= rst_cnt + 1'b1;
					end
				end

				pr_pkg::ST_DONE: begin
					state <= pr_pkg::ST_IDLE;
				end

				default: begin
					state <= pr_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/axil_txn_tracker.sv
// -------------------------------------------------------------------
// counts outstanding host-side reads and writes per region
// counters wrap silently, CNT_BITS must cover the deepest pipeline
// idle also needs no request valid waiting on aw, w or ar
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axil_txn_tracker #(
	parameter int N_REGIONS = 2,
	parameter int CNT_BITS  = 4
) (
	input  wire                 aclk,
	input  wire                 arst_n,
	input  wire [N_REGIONS-1:0] awvalid,
	input  wire [N_REGIONS-1:0] awready,
	input  wire [N_REGIONS-1:0] wvalid,
	input  wire [N_REGIONS-1:0] bvalid,
	input  wire [N_REGIONS-1:0] bready,
	input  wire [N_REGIONS-1:0] arvalid,
	input  wire [N_REGIONS-1:0] arready,
	input  wire [N_REGIONS-1:0] rvalid,
	input  wire [N_REGIONS-1:0] rready,
	output logic [N_REGIONS-1:0] region_idle
);

	logic [N_REGIONS-1:0][CNT_BITS-1:0] wr_cnt;
	logic [N_REGIONS-1:0][CNT_BITS-1:0] rd_cnt;
	logic [N_REGIONS-1:0]               aw_hs;
	logic [N_REGIONS-1:0]               b_hs;
	logic [N_REGIONS-1:0]               ar_hs;
	logic [N_REGIONS-1:0]               r_hs;

	// up/down step, both at once cancels out
	function automatic logic [CNT_BITS-1:0] step(input logic [CNT_BITS-1:0] cnt,
			input logic up, input logic down);
		case ({up, down})
			2'b10:   return cnt + 1'b1;
			2'b01:   return cnt - 1'b1;
			default: return cnt;
		endcase
	endfunction

	// handshakes as seen by the host
	assign aw_hs = awvalid & awready;
	assign b_hs  = bvalid & bready;
	assign ar_hs = arvalid & arready;
	assign r_hs  = rvalid & rready;

	for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
		always_ff @(posedge aclk or negedge arst_n) begin
			if (!arst_n) begin
				wr_cnt[i] <= '0;
				rd_cnt[i] <= '0;
			end else begin
				wr_cnt[i] <= step(wr_cnt[i], aw_hs[i], b_hs[i]);
				rd_cnt[i] <= step(rd_cnt[i], ar_hs[i], r_hs[i]);
			end
		end

		// safe to decouple: nothing in flight and nothing knocking
		assign region_idle[i] = (wr_cnt[i] == '0) && (rd_cnt[i] == '0) &&
			!awvalid[i] && !wvalid[i] && !arvalid[i];
	end

endmodule

`default_nettype wire

//--- verilog/axil_decoupler.sv
// -------------------------------------------------------------------
// gates valid and ready of all five AXI4-Lite channels per region
// payloads pass through untouched, zero cycles of latency
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axil_decoupler #(
	parameter int N_REGIONS = 2,
	parameter int ADDR_BITS = 12,
	parameter int DATA_BITS = 32
) (
	input  wire [N_REGIONS-1:0]                               decouple,

	// host side
	input  wire [N_REGIONS-1:0][ADDR_BITS-1:0]                s_axil_awaddr,
	input  wire [N_REGIONS-1:0][axil_pkg::AXIL_PROT_BITS-1:0] s_axil_awprot,
	input  wire [N_REGIONS-1:0]                               s_axil_awvalid,
	output logic [N_REGIONS-1:0]                              s_axil_awready,
	input  wire [N_REGIONS-1:0][DATA_BITS-1:0]                s_axil_wdata,
	input  wire [N_REGIONS-1:0][DATA_BITS/8-1:0]              s_axil_wstrb,
	input  wire [N_REGIONS-1:0]                               s_axil_wvalid,
	output logic [N_REGIONS-1:0]                              s_axil_wready,
	output logic [N_REGIONS-1:0][axil_pkg::AXIL_RESP_BITS-1:0] s_axil_bresp,
	output logic [N_REGIONS-1:0]                              s_axil_bvalid,
	input  wire [N_REGIONS-1:0]                               s_axil_bready,
	input  wire [N_REGIONS-1:0][ADDR_BITS-1:0]                s_axil_araddr,
	input  wire [N_REGIONS-1:0][axil_pkg::AXIL_PROT_BITS-1:0] s_axil_arprot,
	input  wire [N_REGIONS-1:0]                               s_axil_arvalid,
	output logic [N_REGIONS-1:0]                              s_axil_arready,
	output logic [N_REGIONS-1:0][DATA_BITS-1:0]               s_axil_rdata,
	output logic [N_REGIONS-1:0][axil_pkg::AXIL_RESP_BITS-1:0] s_axil_rresp,
	output logic [N_REGIONS-1:0]                              s_axil_rvalid,
	input  wire [N_REGIONS-1:0]                               s_axil_rready,

	// region side
	output logic [N_REGIONS-1:0][ADDR_BITS-1:0]               m_axil_awaddr,
	output logic [N_REGIONS-1:0][axil_pkg::AXIL_PROT_BITS-1:0] m_axil_awprot,
	output logic [N_REGIONS-1:0]                              m_axil_awvalid,
	input  wire [N_REGIONS-1:0]                               m_axil_awready,
	output logic [N_REGIONS-1:0][DATA_BITS-1:0]               m_axil_wdata,
	output logic [N_REGIONS-1:0][DATA_BITS/8-1:0]             m_axil_wstrb,
	output logic [N_REGIONS-1:0]                              m_axil_wvalid,
	input  wire [N_REGIONS-1:0]                               m_axil_wready,
	input  wire [N_REGIONS-1:0][axil_pkg::AXIL_RESP_BITS-1:0] m_axil_bresp,
	input  wire [N_REGIONS-1:0]                               m_axil_bvalid,
	output logic [N_REGIONS-1:0]                              m_axil_bready,
	output logic [N_REGIONS-1:0][ADDR_BITS-1:0]               m_axil_araddr,
	output logic [N_REGIONS-1:0][axil_pkg::AXIL_PROT_BITS-1:0] m_axil_arprot,
	output logic [N_REGIONS-1:0]                              m_axil_arvalid,
	input  wire [N_REGIONS-1:0]                               m_axil_arready,
	input  wire [N_REGIONS-1:0][DATA_BITS-1:0]                m_axil_rdata,
	input  wire [N_REGIONS-1:0][axil_pkg::AXIL_RESP_BITS-1:0] m_axil_rresp,
	input  wire [N_REGIONS-1:0]                               m_axil_rvalid,
	output logic [N_REGIONS-1:0]                              m_axil_rready
);

	// -------------------------------------------------------------------
	// handshake gating, bit i of decouple masks region i
	// -------------------------------------------------------------------

	// aw and w, host to region
	assign m_axil_awvalid = s_axil_awvalid & ~decouple;
	assign s_axil_awready = m_axil_awready & ~decouple;
	assign m_axil_wvalid  = s_axil_wvalid & ~decouple;
	assign s_axil_wready  = m_axil_wready & ~decouple;

	// b, region to host
	assign s_axil_bvalid = m_axil_bvalid & ~decouple;
	assign m_axil_bready = s_axil_bready & ~decouple;

	// ar and r
	assign m_axil_arvalid = s_axil_arvalid & ~decouple;
	assign s_axil_arready = m_axil_arready & ~decouple;
	assign s_axil_rvalid  = m_axil_rvalid & ~decouple;
	assign m_axil_rready  = s_axil_rready & ~decouple;

	// -------------------------------------------------------------------
	// payloads, never gated
	// -------------------------------------------------------------------
	assign m_axil_awaddr = s_axil_awaddr;
	assign m_axil_awprot = s_axil_awprot;
	assign m_axil_wdata  = s_axil_wdata;
	assign m_axil_wstrb  = s_axil_wstrb;
	assign s_axil_bresp  = m_axil_bresp;
	assign m_axil_araddr = s_axil_araddr;
	assign m_axil_arprot = s_axil_arprot;
	assign s_axil_rdata  = m_axil_rdata;
	assign s_axil_rresp  = m_axil_rresp;

endmodule

`default_nettype wire

//--- verilog/pr_pkg.sv
// -------------------------------------------------------------------
// reconfiguration control encodings
// opcode 2'b11 is unused and is treated like a nop
// -------------------------------------------------------------------
`default_nettype none

package pr_pkg;

	// controller states, one region handled at a time
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_DRAIN = 2'd1,
		ST_RESET = 2'd2,
		ST_DONE  = 2'd3
	} pr_state_e;

	// host command opcodes
	typedef enum logic [1:0] {
		CMD_NOP      = 2'd0,
		CMD_DECOUPLE = 2'd1,
		CMD_COUPLE   = 2'd2
	} pr_cmd_e;

endpackage

`default_nettype wire

//--- verilog/axil_pkg.sv
// -------------------------------------------------------------------
// AXI4-Lite definitions shared by the shell RTL
// only OKAY and SLVERR are ever returned, no EXOKAY or DECERR
// -------------------------------------------------------------------
`default_nettype none

package axil_pkg;

	// field widths on the bus
	localparam int AXIL_RESP_BITS = 2;
	localparam int AXIL_PROT_BITS = 3;

	// response codes
	typedef enum logic [AXIL_RESP_BITS-1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	// words in each region's register file
	localparam int REG_WORDS = 4;

endpackage

`default_nettype wire
